// ==== decoder_defines.svh ====
/* width macros for the decode stage, included by the package and the classifier */
`ifndef DECODER_DEFINES_SVH
`define DECODER_DEFINES_SVH

// data path and instruction word
`define DEC_XLEN 32

// register indices and tags
`define DEC_AREG_W 5
`define DEC_PREG_W 6

`define DEC_PC_W 32

// micro-op is split into a class and a sub-op
`define DEC_UOP_HI_W 3
`define DEC_UOP_LO_W 3

`endif

// ==== decoder_pkg.sv ====
/* types shared by the decode stage: widths with a meaning, FSM states and
   the RV32I/M major opcodes; referenced by scoped name */
`include "decoder_defines.svh"

package decoder_pkg;

    typedef logic [`DEC_XLEN-1:0]                     word_t;
    typedef logic [`DEC_AREG_W-1:0]                   areg_t;
    typedef logic [`DEC_PREG_W-1:0]                   preg_t;
    typedef logic [`DEC_PC_W-1:0]                     pc_t;
    typedef logic [`DEC_UOP_HI_W+`DEC_UOP_LO_W-1:0]   uop_t;

    typedef enum logic [2:0] {
        FMT_R    = 3'd0,
        FMT_I    = 3'd1,
        FMT_S    = 3'd2,
        FMT_B    = 3'd3,
        FMT_U    = 3'd4,
        FMT_J    = 3'd5,
        FMT_NONE = 3'd7
    } instr_fmt_e;

    typedef enum logic [3:0] {
        PIPE_NONE = 4'd0,
        PIPE_EXEC = 4'd1,
        PIPE_DIV  = 4'd2,
        PIPE_CSR  = 4'd3,
        PIPE_LSU  = 4'd4
    } pipe_e;

    typedef enum logic [1:0] {SRC_IDLE, SRC_REQ, SRC_READY, SRC_WAIT_WB} src_state_e;
    typedef enum logic [1:0] {DST_IDLE, DST_REQ, DST_READY} dst_state_e;

    ////////////////////////////////////////////////////////////
    // major opcodes
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

endpackage

// ==== decode_if.sv ====
/* classifier results for the latched instruction; the classifier drives it,
   the stage control and the top level read it */
interface decode_if;

    decoder_pkg::instr_fmt_e fmt;
    decoder_pkg::pipe_e      pipe;
    decoder_pkg::uop_t       uop;

    // which registers the instruction touches
    logic                    need_r1;
    logic                    need_r2;
    logic                    need_rd;

    decoder_pkg::areg_t      rs1;
    decoder_pkg::areg_t      rs2;
    decoder_pkg::areg_t      rd;

    modport drv (output fmt, pipe, uop, need_r1, need_r2, need_rd, rs1, rs2, rd);
    modport rdr (input fmt, pipe, uop, need_r1, need_r2, need_rd, rs1, rs2, rd);

endinterface

// ==== operand_if.sv ====
/* link between the stage control and one source tracker, start and rel are
   single-cycle pulses from the control */
interface operand_if;

    logic               start;
    // release pulse, the held instruction leaves in this cycle
    logic               rel;

    logic               done;
    logic               rdy;
    decoder_pkg::preg_t preg;
    decoder_pkg::word_t data;

    modport ctrl (output start, rel, input done, rdy, preg, data);
    modport trk  (input start, rel, output done, rdy, preg, data);

endinterface

// ==== instr_classifier.sv ====
/* combinational RV32I/M classifier: format, issue pipe, micro-op, operand
   needs and register fields of the latched instruction */
`include "decoder_defines.svh"

module instr_classifier (
    input  decoder_pkg::word_t i_instr,
    decode_if.drv              dec
);

    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic                     is_div;
    logic [`DEC_UOP_HI_W-1:0] uop_cls;
    logic [`DEC_UOP_LO_W-1:0] uop_sub;

    ////////////////////////////////////////////////////////////
    // field slicing
    assign opcode  = i_instr[6:0];
    assign funct3  = i_instr[14:12];
    assign funct7  = i_instr[31:25];
    assign dec.rd  = i_instr[11:7];
    assign dec.rs1 = i_instr[19:15];
    assign dec.rs2 = i_instr[24:20];

    // M extension div/rem ops
    assign is_div  = (funct7 == 7'b0000001) && (funct3 >= 3'd4);

    always_comb begin
        case (opcode)
            decoder_pkg::OPC_OP:     dec.fmt = decoder_pkg::FMT_R;
            decoder_pkg::OPC_OP_IMM,
            decoder_pkg::OPC_JALR,
            decoder_pkg::OPC_LOAD,
            decoder_pkg::OPC_LUI,
            decoder_pkg::OPC_MISC_MEM,
            decoder_pkg::OPC_SYSTEM: dec.fmt = decoder_pkg::FMT_I;
            decoder_pkg::OPC_STORE:  dec.fmt = decoder_pkg::FMT_S;
            decoder_pkg::OPC_BRANCH: dec.fmt = decoder_pkg::FMT_B;
            decoder_pkg::OPC_AUIPC:  dec.fmt = decoder_pkg::FMT_U;
            decoder_pkg::OPC_JAL:    dec.fmt = decoder_pkg::FMT_J;
            default:                 dec.fmt = decoder_pkg::FMT_NONE;
        endcase
    end

    // operand needs follow the format
    assign dec.need_r1 = dec.fmt inside {decoder_pkg::FMT_R, decoder_pkg::FMT_I,
                                         decoder_pkg::FMT_S, decoder_pkg::FMT_B};
    assign dec.need_r2 = dec.fmt inside {decoder_pkg::FMT_R, decoder_pkg::FMT_S,
                                         decoder_pkg::FMT_B};
    assign dec.need_rd = dec.fmt inside {decoder_pkg::FMT_R, decoder_pkg::FMT_I,
                                         decoder_pkg::FMT_U, decoder_pkg::FMT_J};

    always_comb begin
        case (opcode)
            decoder_pkg::OPC_OP,
            decoder_pkg::OPC_OP_IMM,
            decoder_pkg::OPC_BRANCH,
            decoder_pkg::OPC_AUIPC,
            decoder_pkg::OPC_JAL,
            decoder_pkg::OPC_JALR:
                dec.pipe = is_div ? decoder_pkg::PIPE_DIV : decoder_pkg::PIPE_EXEC;
            decoder_pkg::OPC_LOAD,
            decoder_pkg::OPC_LUI,
            decoder_pkg::OPC_STORE,
            decoder_pkg::OPC_MISC_MEM: dec.pipe = decoder_pkg::PIPE_LSU;
            decoder_pkg::OPC_SYSTEM:   dec.pipe = decoder_pkg::PIPE_CSR;
            default:                   dec.pipe = decoder_pkg::PIPE_NONE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // micro-op, class in the upper half
    always_comb begin
        uop_cls = 3'd0;
        uop_sub = funct3;
        case (opcode)
            decoder_pkg::OPC_OP: begin
                if (funct7 == 7'b0100000) begin
                    // sub and sra
                    uop_cls = 3'd1;
                    uop_sub = (funct3 == 3'd0) ? 3'd4 : 3'd5;
                end else if (funct7 == 7'b0000001) begin
                    uop_cls = 3'd1;
                end
            end
            decoder_pkg::OPC_OP_IMM:   uop_cls = 3'd2;
            decoder_pkg::OPC_BRANCH:   uop_cls = 3'd3;
            decoder_pkg::OPC_AUIPC: begin
                uop_cls = 3'd4;
                uop_sub = 3'd0;
            end
            decoder_pkg::OPC_JAL: begin
                uop_cls = 3'd4;
                uop_sub = 3'd1;
            end
            decoder_pkg::OPC_JALR: begin
                uop_cls = 3'd4;
                uop_sub = 3'd2;
            end
            decoder_pkg::OPC_LOAD:     uop_cls = 3'd0;
            decoder_pkg::OPC_LUI:      uop_sub = 3'd3;
            decoder_pkg::OPC_STORE:    uop_cls = 3'd1;
            decoder_pkg::OPC_MISC_MEM: uop_cls = 3'd2;
            decoder_pkg::OPC_SYSTEM: begin
                // ecall or ebreak picked by bit 20
                if (funct3 == 3'd0) begin
                    uop_sub = {2'b00, i_instr[20]};
                end else begin
                    uop_cls = 3'd1;
                end
            end
            default:                   uop_sub = 3'd0;
        endcase
    end

    assign dec.uop = {uop_cls, uop_sub};

endmodule

// ==== src_operand_tracker.sv ====
/* one source operand: books its tag at rename, then snoops the writeback
   broadcast until the value shows up */
module src_operand_tracker (
    input  logic               con_cmd,
    input  logic               i_rst_n,
    operand_if.trk             op,
    input  logic               i_need,
    input  logic               i_grant,
    input  decoder_pkg::preg_t i_ren_preg,
    input  logic               i_ren_rdy,
    input  decoder_pkg::word_t i_ren_data,
    input  logic               i_wb_valid,
    input  decoder_pkg::preg_t i_wb_preg,
    input  decoder_pkg::word_t i_wb_data
);

    decoder_pkg::src_state_e state_q;
    decoder_pkg::src_state_e state_d;
    logic                    rdy_q;
    decoder_pkg::preg_t      preg_q;
    decoder_pkg::word_t      data_q;
    logic                    grant_hit;
    logic                    wb_hit;

    assign grant_hit = (state_q == decoder_pkg::SRC_REQ) && i_grant;
    assign wb_hit    = (state_q == decoder_pkg::SRC_WAIT_WB) && i_wb_valid
                       && (i_wb_preg == preg_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            decoder_pkg::SRC_IDLE:
                if (op.start) state_d = decoder_pkg::SRC_REQ;
            decoder_pkg::SRC_REQ:
                if (i_grant) begin
                    state_d = (i_need && !i_ren_rdy) ? decoder_pkg::SRC_WAIT_WB
                                                     : decoder_pkg::SRC_READY;
                end
            default: begin
                // leaving wins over a late wakeup
                if (op.rel) begin
                    state_d = op.start ? decoder_pkg::SRC_REQ : decoder_pkg::SRC_IDLE;
                end else if (wb_hit) begin
                    state_d = decoder_pkg::SRC_READY;
                end
            end
        endcase
    end

    always_ff @(posedge con_cmd or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= decoder_pkg::SRC_IDLE;
            rdy_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (op.rel) begin
                rdy_q <= 1'b0;
            end else if (grant_hit) begin
                rdy_q <= !i_need || i_ren_rdy;
            end else if (wb_hit) begin
                rdy_q <= 1'b1;
            end
        end
    end

    // tag and value, unneeded sources read as zero
    always_ff @(posedge con_cmd) begin
        if (grant_hit) begin
            preg_q <= i_ren_preg;
            data_q <= (i_need && i_ren_rdy) ? i_ren_data : '0;
        end else if (wb_hit) begin
            data_q <= i_wb_data;
        end
    end

    assign op.done = (state_q == decoder_pkg::SRC_READY) || (state_q == decoder_pkg::SRC_WAIT_WB);
    assign op.rdy  = rdy_q;
    assign op.preg = preg_q;
    assign op.data = data_q;

    // a booked value stays ready until the instruction leaves
    a_rdy_hold: assert property (@(posedge con_cmd) disable iff (!i_rst_n)
        (op.done && op.rdy && !op.rel) |=> op.rdy);

endmodule

// ==== decode_stage_ctrl.sv ====
/* decode stage control: instruction latch, destination booking with the
   rename unit, accept and output-valid handshake levels */
module decode_stage_ctrl (
    input  logic               con_cmd,
    input  logic               i_rst_n,
    input  logic               i_instr_valid,
    input  decoder_pkg::word_t i_instr,
    input  decoder_pkg::pc_t   i_pc,
    input  logic               i_stall,
    input  logic               i_ren_grant,
    input  decoder_pkg::preg_t i_ren_preg_rd,
    decode_if.rdr              dec,
    operand_if.ctrl            src_r1,
    operand_if.ctrl            src_r2,
    output decoder_pkg::word_t o_instr,
    output logic               o_ready,
    output logic               o_ren_req,
    output logic               o_dec_valid,
    output decoder_pkg::word_t o_dec_instr,
    output decoder_pkg::pc_t   o_dec_pc,
    output decoder_pkg::preg_t o_dec_preg_rd
);

    decoder_pkg::dst_state_e dst_q;
    decoder_pkg::dst_state_e dst_d;
    decoder_pkg::word_t      instr_q;
    decoder_pkg::pc_t        pc_q;
    decoder_pkg::preg_t      preg_rd_q;
    logic                    accept;
    logic                    fire;

    ////////////////////////////////////////////////////////////
    // handshake
    assign fire        = o_dec_valid && !i_stall;
    assign accept      = i_instr_valid && o_ready;
    // all bookings move together, so dst idle means the trackers are idle too
    assign o_ready     = (dst_q == decoder_pkg::DST_IDLE) || fire;
    assign o_dec_valid = (dst_q == decoder_pkg::DST_READY) && src_r1.done && src_r2.done;
    assign o_ren_req   = (dst_q == decoder_pkg::DST_REQ);

    assign src_r1.start = accept;
    assign src_r2.start = accept;
    assign src_r1.rel   = fire;
    assign src_r2.rel   = fire;

    always_ff @(posedge con_cmd) begin
        if (accept) begin
            instr_q <= i_instr;
            pc_q    <= i_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // destination booking
    always_comb begin
        dst_d = dst_q;
        case (dst_q)
            decoder_pkg::DST_IDLE:
                if (accept) dst_d = decoder_pkg::DST_REQ;
            decoder_pkg::DST_REQ:
                if (i_ren_grant) dst_d = decoder_pkg::DST_READY;
            default:
                if (fire) dst_d = accept ? decoder_pkg::DST_REQ : decoder_pkg::DST_IDLE;
        endcase
    end

    always_ff @(posedge con_cmd or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dst_q <= decoder_pkg::DST_IDLE;
        end else begin
            dst_q <= dst_d;
        end
    end

    always_ff @(posedge con_cmd) begin
        if (o_ren_req && i_ren_grant) begin
            preg_rd_q <= dec.need_rd ? i_ren_preg_rd : '0;
        end
    end

    assign o_instr       = instr_q;
    assign o_dec_instr   = instr_q;
    assign o_dec_pc      = pc_q;
    assign o_dec_preg_rd = preg_rd_q;

    a_valid_held: assert property (@(posedge con_cmd) disable iff (!i_rst_n)
        (o_dec_valid && i_stall) |=> o_dec_valid);

    // a new booking only starts on empty or departing trackers
    a_start_free: assert property (@(posedge con_cmd) disable iff (!i_rst_n)
        src_r1.start |-> (src_r1.rel || (!src_r1.done && !src_r2.done
                                         && dst_q == decoder_pkg::DST_IDLE)));

endmodule

// ==== decode_stage.sv ====
/* decode stage top level: classifier, two source trackers and the control,
   rename and writeback buses on plain ports */
module decode_stage (
    input  logic               con_cmd,
    input  logic               i_rst_n,
    input  logic               i_instr_valid,
    input  decoder_pkg::word_t i_instr,
    input  decoder_pkg::pc_t   i_pc,
    input  logic               i_stall,
    // rename response, valid in the grant cycle
    input  logic               i_ren_grant,
    input  decoder_pkg::preg_t i_ren_preg_rd,
    input  decoder_pkg::preg_t i_ren_preg_r1,
    input  logic               i_ren_rdy_r1,
    input  decoder_pkg::word_t i_ren_data_r1,
    input  decoder_pkg::preg_t i_ren_preg_r2,
    input  logic               i_ren_rdy_r2,
    input  decoder_pkg::word_t i_ren_data_r2,
    // writeback broadcast
    input  logic               i_wb_valid,
    input  decoder_pkg::preg_t i_wb_preg,
    input  decoder_pkg::word_t i_wb_data,
    output logic               o_ready,
    output logic               o_ren_req,
    output decoder_pkg::areg_t o_ren_areg_r1,
    output decoder_pkg::areg_t o_ren_areg_r2,
    output decoder_pkg::areg_t o_ren_areg_rd,
    output decoder_pkg::pipe_e o_ren_pipe,
    output decoder_pkg::uop_t  o_ren_uop,
    output logic               o_dec_valid,
    output decoder_pkg::word_t o_dec_instr,
    output decoder_pkg::pc_t   o_dec_pc,
    output decoder_pkg::pipe_e o_dec_pipe,
    output decoder_pkg::uop_t  o_dec_uop,
    output decoder_pkg::preg_t o_dec_preg_rd,
    output decoder_pkg::preg_t o_dec_preg_r1,
    output decoder_pkg::preg_t o_dec_preg_r2,
    output logic               o_dec_rdy_r1,
    output logic               o_dec_rdy_r2,
    output decoder_pkg::word_t o_dec_data_r1,
    output decoder_pkg::word_t o_dec_data_r2
);

    decoder_pkg::word_t latched_instr;

    decode_if  dec ();
    operand_if op_r1 ();
    operand_if op_r2 ();

    decode_stage_ctrl u_ctrl (
        .con_cmd       (con_cmd),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_stall       (i_stall),
        .i_ren_grant   (i_ren_grant),
        .i_ren_preg_rd (i_ren_preg_rd),
        .dec           (dec),
        .src_r1        (op_r1),
        .src_r2        (op_r2),
        .o_instr       (latched_instr),
        .o_ready       (o_ready),
        .o_ren_req     (o_ren_req),
        .o_dec_valid   (o_dec_valid),
        .o_dec_instr   (o_dec_instr),
        .o_dec_pc      (o_dec_pc),
        .o_dec_preg_rd (o_dec_preg_rd)
    );

    instr_classifier u_classifier (
        .i_instr (latched_instr),
        .dec     (dec)
    );

    src_operand_tracker u_src_r1 (
        .con_cmd    (con_cmd),
        .i_rst_n    (i_rst_n),
        .op         (op_r1),
        .i_need     (dec.need_r1),
        .i_grant    (i_ren_grant),
        .i_ren_preg (i_ren_preg_r1),
        .i_ren_rdy  (i_ren_rdy_r1),
        .i_ren_data (i_ren_data_r1),
        .i_wb_valid (i_wb_valid),
        .i_wb_preg  (i_wb_preg),
        .i_wb_data  (i_wb_data)
    );

    src_operand_tracker u_src_r2 (
        .con_cmd    (con_cmd),
        .i_rst_n    (i_rst_n),
        .op         (op_r2),
        .i_need     (dec.need_r2),
        .i_grant    (i_ren_grant),
        .i_ren_preg (i_ren_preg_r2),
        .i_ren_rdy  (i_ren_rdy_r2),
        .i_ren_data (i_ren_data_r2),
        .i_wb_valid (i_wb_valid),
        .i_wb_preg  (i_wb_preg),
        .i_wb_data  (i_wb_data)
    );

    // classifier fields feed both the rename request and the decoded output
    assign o_ren_areg_r1 = dec.rs1;
    assign o_ren_areg_r2 = dec.rs2;
    assign o_ren_areg_rd = dec.rd;
    assign o_ren_pipe    = dec.pipe;
    assign o_ren_uop     = dec.uop;
    assign o_dec_pipe    = dec.pipe;
    assign o_dec_uop     = dec.uop;

    assign o_dec_preg_r1 = op_r1.preg;
    assign o_dec_preg_r2 = op_r2.preg;
    assign o_dec_rdy_r1  = op_r1.rdy;
    assign o_dec_rdy_r2  = op_r2.rdy;
    assign o_dec_data_r1 = op_r1.data;
    assign o_dec_data_r2 = op_r2.data;

endmodule

// ==== tb_decode_stage.sv ====
/* table-driven testbench for the decode stage that plays the rename unit and the
   writeback bus and checks every decoded output */
module tb_decode_stage;

    localparam int NROWS      = 17;
    localparam int MAX_CYCLES = NROWS * 16 + 40;

    typedef struct {
        decoder_pkg::word_t instr;
        decoder_pkg::pc_t   pc;
        decoder_pkg::preg_t tag_rd;
        decoder_pkg::preg_t tag_r1;
        decoder_pkg::preg_t tag_r2;
        logic               rdy_r1;
        logic               rdy_r2;
        decoder_pkg::word_t data_r1;
        decoder_pkg::word_t data_r2;
        logic               wake;
        decoder_pkg::pipe_e pipe;
        decoder_pkg::uop_t  uop;
        logic [2:0]         need;
    } row_t;

    logic               con_cmd;
    logic               i_rst_n;
    logic               i_instr_valid;
    decoder_pkg::word_t i_instr;
    decoder_pkg::pc_t   i_pc;
    logic               i_stall;
    logic               i_ren_grant;
    decoder_pkg::preg_t i_ren_preg_rd;
    decoder_pkg::preg_t i_ren_preg_r1;
    logic               i_ren_rdy_r1;
    decoder_pkg::word_t i_ren_data_r1;
    decoder_pkg::preg_t i_ren_preg_r2;
    logic               i_ren_rdy_r2;
    decoder_pkg::word_t i_ren_data_r2;
    logic               i_wb_valid;
    decoder_pkg::preg_t i_wb_preg;
    decoder_pkg::word_t i_wb_data;
    logic               o_ready;
    logic               o_ren_req;
    decoder_pkg::areg_t o_ren_areg_r1;
    decoder_pkg::areg_t o_ren_areg_r2;
    decoder_pkg::areg_t o_ren_areg_rd;
    decoder_pkg::pipe_e o_ren_pipe;
    decoder_pkg::uop_t  o_ren_uop;
    logic               o_dec_valid;
    decoder_pkg::word_t o_dec_instr;
    decoder_pkg::pc_t   o_dec_pc;
    decoder_pkg::pipe_e o_dec_pipe;
    decoder_pkg::uop_t  o_dec_uop;
    decoder_pkg::preg_t o_dec_preg_rd;
    decoder_pkg::preg_t o_dec_preg_r1;
    decoder_pkg::preg_t o_dec_preg_r2;
    logic               o_dec_rdy_r1;
    logic               o_dec_rdy_r2;
    decoder_pkg::word_t o_dec_data_r1;
    decoder_pkg::word_t o_dec_data_r2;

    row_t               tbl [NROWS];
    string              row_name [NROWS];
    string              cur_name;
    int                 cycle_cnt;
    logic               exp_rdy1;
    logic               exp_rdy2;
    decoder_pkg::word_t exp_data1;
    decoder_pkg::word_t exp_data2;

    decode_stage i_decode_stage (
        .con_cmd       (con_cmd),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_stall       (i_stall),
        .i_ren_grant   (i_ren_grant),
        .i_ren_preg_rd (i_ren_preg_rd),
        .i_ren_preg_r1 (i_ren_preg_r1),
        .i_ren_rdy_r1  (i_ren_rdy_r1),
        .i_ren_data_r1 (i_ren_data_r1),
        .i_ren_preg_r2 (i_ren_preg_r2),
        .i_ren_rdy_r2  (i_ren_rdy_r2),
        .i_ren_data_r2 (i_ren_data_r2),
        .i_wb_valid    (i_wb_valid),
        .i_wb_preg     (i_wb_preg),
        .i_wb_data     (i_wb_data),
        .o_ready       (o_ready),
        .o_ren_req     (o_ren_req),
        .o_ren_areg_r1 (o_ren_areg_r1),
        .o_ren_areg_r2 (o_ren_areg_r2),
        .o_ren_areg_rd (o_ren_areg_rd),
        .o_ren_pipe    (o_ren_pipe),
        .o_ren_uop     (o_ren_uop),
        .o_dec_valid   (o_dec_valid),
        .o_dec_instr   (o_dec_instr),
        .o_dec_pc      (o_dec_pc),
        .o_dec_pipe    (o_dec_pipe),
        .o_dec_uop     (o_dec_uop),
        .o_dec_preg_rd (o_dec_preg_rd),
        .o_dec_preg_r1 (o_dec_preg_r1),
        .o_dec_preg_r2 (o_dec_preg_r2),
        .o_dec_rdy_r1  (o_dec_rdy_r1),
        .o_dec_rdy_r2  (o_dec_rdy_r2),
        .o_dec_data_r1 (o_dec_data_r1),
        .o_dec_data_r2 (o_dec_data_r2)
    );

    always #20 con_cmd = ~con_cmd;

    // run limit in clock cycles
    always @(posedge con_cmd) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the DUT made no progress within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     cur_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    task automatic set_row(input int idx, input string name, input logic [31:0] instr,
                           input logic rdy_r1, input logic rdy_r2, input logic wake,
                           input decoder_pkg::pipe_e pipe, input logic [5:0] uop,
                           input logic [2:0] need);
        row_name[idx]     = name;
        tbl[idx].instr    = instr;
        tbl[idx].pc       = 32'h0000_1000 + 4 * idx;
        // tags are unique over the table so no wakeup goes astray
        tbl[idx].tag_rd   = 3 * idx + 1;
        tbl[idx].tag_r1   = 3 * idx + 2;
        tbl[idx].tag_r2   = 3 * idx + 3;
        tbl[idx].rdy_r1   = rdy_r1;
        tbl[idx].rdy_r2   = rdy_r2;
        tbl[idx].data_r1  = 32'hA100_0000 + idx;
        tbl[idx].data_r2  = 32'hB200_0000 + idx;
        tbl[idx].wake     = wake;
        tbl[idx].pipe     = pipe;
        tbl[idx].uop      = uop;
        tbl[idx].need     = need;
    endtask

    ////////////////////////////////////////////////////////////
    // table columns are name, word, rdy r1/r2, wake, pipe, uop and need {r1,r2,rd}
    task automatic load_table();
        set_row(0, "add", 32'h002081B3, 1, 0, 1, decoder_pkg::PIPE_EXEC, 6'h00, 3'b111);
        set_row(1, "sub", 32'h407302B3, 1, 1, 0, decoder_pkg::PIPE_EXEC, 6'h0C, 3'b111);
        set_row(2, "sra", 32'h40A4D433, 0, 1, 1, decoder_pkg::PIPE_EXEC, 6'h0D, 3'b111);
        set_row(3, "div", 32'h02D645B3, 0, 0, 1, decoder_pkg::PIPE_DIV, 6'h0C, 3'b111);
        set_row(4, "mul", 32'h03078733, 1, 1, 0, decoder_pkg::PIPE_EXEC, 6'h08, 3'b111);
        set_row(5, "addi", 32'h00510093, 1, 0, 0, decoder_pkg::PIPE_EXEC, 6'h10, 3'b101);
        set_row(6, "bne", 32'h00209063, 0, 1, 0, decoder_pkg::PIPE_EXEC, 6'h19, 3'b110);
        set_row(7, "auipc", 32'h12345217, 0, 0, 0, decoder_pkg::PIPE_EXEC, 6'h20, 3'b001);
        set_row(8, "jal", 32'h000000EF, 1, 1, 0, decoder_pkg::PIPE_EXEC, 6'h21, 3'b001);
        set_row(9, "jalr", 32'h00008067, 1, 0, 0, decoder_pkg::PIPE_EXEC, 6'h22, 3'b101);
        set_row(10, "lw", 32'h00812283, 0, 1, 1, decoder_pkg::PIPE_LSU, 6'h02, 3'b101);
        set_row(11, "lui", 32'hABCDE337, 1, 1, 0, decoder_pkg::PIPE_LSU, 6'h03, 3'b101);
        set_row(12, "sw", 32'h00742223, 1, 0, 1, decoder_pkg::PIPE_LSU, 6'h0A, 3'b110);
        set_row(13, "fence", 32'h0FF0000F, 1, 1, 0, decoder_pkg::PIPE_LSU, 6'h10, 3'b101);
        set_row(14, "ebreak", 32'h00100073, 1, 1, 0, decoder_pkg::PIPE_CSR, 6'h01, 3'b101);
        set_row(15, "csrrw", 32'h300110F3, 1, 1, 0, decoder_pkg::PIPE_CSR, 6'h09, 3'b101);
        set_row(16, "custom", 32'h0040050B, 0, 0, 0, decoder_pkg::PIPE_NONE, 6'h00, 3'b000);
    endtask

    // full decoded output while the instruction is held
    task automatic check_held(input int r);
        check_value("o_dec_valid", 1'b1, o_dec_valid);
        check_value("o_ren_req", 1'b0, o_ren_req);
        check_value("o_ready", 1'b0, o_ready);
        check_value("o_dec_instr", tbl[r].instr, o_dec_instr);
        check_value("o_dec_pc", tbl[r].pc, o_dec_pc);
        check_value("o_dec_pipe", tbl[r].pipe, o_dec_pipe);
        check_value("o_dec_uop", tbl[r].uop, o_dec_uop);
        check_value("o_dec_preg_rd", tbl[r].need[0] ? tbl[r].tag_rd : 6'd0, o_dec_preg_rd);
        check_value("o_dec_preg_r1", tbl[r].tag_r1, o_dec_preg_r1);
        check_value("o_dec_preg_r2", tbl[r].tag_r2, o_dec_preg_r2);
        check_value("o_dec_rdy_r1", exp_rdy1, o_dec_rdy_r1);
        check_value("o_dec_rdy_r2", exp_rdy2, o_dec_rdy_r2);
        check_value("o_dec_data_r1", exp_data1, o_dec_data_r1);
        check_value("o_dec_data_r2", exp_data2, o_dec_data_r2);
    endtask

    task automatic drive_instr(input int r);
        i_instr_valid = 1'b1;
        i_instr       = tbl[r].instr;
        i_pc          = tbl[r].pc;
    endtask

    // rename model grants after a random delay and answers for one cycle
    task automatic grant_rename(input int r);
        int delay;
        delay = $urandom % 4;
        repeat (delay) begin
            @(negedge con_cmd);
            check_value("o_ren_req while waiting", 1'b1, o_ren_req);
            check_value("o_dec_valid before grant", 1'b0, o_dec_valid);
        end
        i_ren_grant   = 1'b1;
        i_ren_preg_rd = tbl[r].tag_rd;
        i_ren_preg_r1 = tbl[r].tag_r1;
        i_ren_rdy_r1  = tbl[r].rdy_r1;
        i_ren_data_r1 = tbl[r].rdy_r1 ? tbl[r].data_r1 : ~tbl[r].data_r1;
        i_ren_preg_r2 = tbl[r].tag_r2;
        i_ren_rdy_r2  = tbl[r].rdy_r2;
        i_ren_data_r2 = tbl[r].rdy_r2 ? tbl[r].data_r2 : ~tbl[r].data_r2;
        #5;
        check_value("o_ren_req in grant cycle", 1'b1, o_ren_req);
        check_value("o_dec_valid in grant cycle", 1'b0, o_dec_valid);
        @(negedge con_cmd);
        i_ren_grant   = 1'b0;
        i_ren_rdy_r1  = 1'b0;
        i_ren_rdy_r2  = 1'b0;
        i_ren_data_r1 = '0;
        i_ren_data_r2 = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // runs one row from the falling edge where it is offered
    task automatic run_row(input int r);
        int  hold;
        logic wake1;
        logic wake2;
        cur_name = row_name[r];
        #5;
        check_value("o_ready at accept", 1'b1, o_ready);
        @(negedge con_cmd);
        i_stall = 1'b1;
        // the next row waits at the input until the fire cycle
        if (r + 1 < NROWS) begin
            drive_instr(r + 1);
        end else begin
            i_instr_valid = 1'b0;
        end
        check_value("o_ren_req", 1'b1, o_ren_req);
        check_value("o_ready while booking", 1'b0, o_ready);
        check_value("o_ren_areg_r1", tbl[r].instr[19:15], o_ren_areg_r1);
        check_value("o_ren_areg_r2", tbl[r].instr[24:20], o_ren_areg_r2);
        check_value("o_ren_areg_rd", tbl[r].instr[11:7], o_ren_areg_rd);
        check_value("o_ren_pipe", tbl[r].pipe, o_ren_pipe);
        check_value("o_ren_uop", tbl[r].uop, o_ren_uop);
        grant_rename(r);
        // an unneeded source reads as ready with data zero
        exp_rdy1  = !tbl[r].need[2] || tbl[r].rdy_r1;
        exp_rdy2  = !tbl[r].need[1] || tbl[r].rdy_r2;
        exp_data1 = (tbl[r].need[2] && tbl[r].rdy_r1) ? tbl[r].data_r1 : '0;
        exp_data2 = (tbl[r].need[1] && tbl[r].rdy_r2) ? tbl[r].data_r2 : '0;
        wake1     = tbl[r].wake && !exp_rdy1;
        wake2     = tbl[r].wake && !exp_rdy2;
        check_held(r);
        hold = $urandom % 4;
        if (tbl[r].wake && hold < 2) begin
            hold = 2;
        end
        for (int k = 0; k < hold; k++) begin
            if (k == 0 && wake1) begin
                i_wb_valid = 1'b1;
                i_wb_preg  = tbl[r].tag_r1;
                i_wb_data  = tbl[r].data_r1;
            end else if (k == 1 && wake2) begin
                i_wb_valid = 1'b1;
                i_wb_preg  = tbl[r].tag_r2;
                i_wb_data  = tbl[r].data_r2;
            end
            @(negedge con_cmd);
            if (i_wb_valid && k == 0) begin
                exp_rdy1  = 1'b1;
                exp_data1 = tbl[r].data_r1;
            end else if (i_wb_valid) begin
                exp_rdy2  = 1'b1;
                exp_data2 = tbl[r].data_r2;
            end
            i_wb_valid = 1'b0;
            check_held(r);
        end
        // the fire cycle takes the next row
        i_stall = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h5774));
        con_cmd       = 1'b0;
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_pc          = '0;
        i_stall       = 1'b1;
        i_ren_grant   = 1'b0;
        i_ren_preg_rd = '0;
        i_ren_preg_r1 = '0;
        i_ren_rdy_r1  = 1'b0;
        i_ren_data_r1 = '0;
        i_ren_preg_r2 = '0;
        i_ren_rdy_r2  = 1'b0;
        i_ren_data_r2 = '0;
        i_wb_valid    = 1'b0;
        i_wb_preg     = '0;
        i_wb_data     = '0;
        cycle_cnt     = 0;
        load_table();

        repeat (8) @(negedge con_cmd);
        i_rst_n  = 1'b1;
        cur_name = "reset";
        @(negedge con_cmd);
        check_value("o_dec_valid", 1'b0, o_dec_valid);
        check_value("o_ren_req", 1'b0, o_ren_req);
        check_value("o_ready", 1'b1, o_ready);

        drive_instr(0);
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end

        // the last row leaves and the stage drains
        cur_name = "drain";
        @(negedge con_cmd);
        i_stall = 1'b1;
        check_value("o_dec_valid", 1'b0, o_dec_valid);
        check_value("o_ren_req", 1'b0, o_ren_req);
        check_value("o_ready", 1'b1, o_ready);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
decoder_pkg.sv
decode_if.sv
operand_if.sv
instr_classifier.sv
src_operand_tracker.sv
decode_stage_ctrl.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

export_include_dirs:
  - .

sources:
  - decoder_pkg.sv
  - decode_if.sv
  - operand_if.sv
  - instr_classifier.sv
  - src_operand_tracker.sv
  - decode_stage_ctrl.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_decode_stage.sv
